// File: src/hdr_proc_pkg.sv
package hdr_proc_pkg;

   // ========================================
   // stream geometry
   // ========================================

   // byte lanes per stream word.
   localparam int DATA_BYTES = 8;

   // ========================================
   // vector types
   // ========================================

   // one stream data word.
   typedef logic [DATA_BYTES*8-1:0] data_t;

   // per-lane byte enables.
   typedef logic [DATA_BYTES-1:0] keep_t;

   // byte count or packet length.
   typedef logic [15:0] byte_len_t;

   // prefix word count or prefix word index.
   typedef logic [3:0] pfx_cnt_t;

   // ========================================
   // state machines
   // ========================================

   // drop filter.
   // idle_sop waits for a first beat, pass forwards the body.
   // discard swallows the rest of a dropped packet.
   typedef enum logic [1:0] {
      idle_sop,
      pass,
      discard
   } drop_state_t;

   // truncator.
   // keep forwards beats, flush discards up to the input last beat.
   typedef enum logic {
      keep,
      flush
   } trunc_state_t;

endpackage

// File: src/hdr_drop_filter.sv
module hdr_drop_filter
   import hdr_proc_pkg::*;
(
   input  logic  axi4s_in,
   input  logic  arst_n,
   // input stream.
   input  logic  in_tvalid,
   input  data_t in_tdata,
   input  keep_t in_tkeep,
   input  logic  in_tlast,
   output logic  in_tready,
   // drop configuration.
   input  logic  drop_enable,
   input  logic  drop_mode,
   input  data_t drop_pattern,
   // filtered stream.
   output logic  flt_tvalid,
   output data_t flt_tdata,
   output keep_t flt_tkeep,
   output logic  flt_tlast,
   input  logic  flt_tready
);

   drop_state_t state;
   drop_state_t state_nxt;
   logic        match;
   logic        in_xfer;

   // only the first word of a packet is compared.
   assign match   = drop_enable && (state == idle_sop) && (in_tdata == drop_pattern);
   assign in_xfer = in_tvalid && in_tready;

   // ========================================
   // output steering
   // ========================================
   always_comb begin
      flt_tvalid = in_tvalid;
      flt_tdata  = in_tdata;
      flt_tkeep  = in_tkeep;
      flt_tlast  = in_tlast;
      in_tready  = flt_tready;
      if (state == discard) begin
         // body of a dropped packet is consumed silently.
         flt_tvalid = 1'b0;
         in_tready  = 1'b1;
      end else if (match) begin
         if (drop_mode) begin
            // mode 1 lets nothing of the packet leave.
            flt_tvalid = 1'b0;
            in_tready  = 1'b1;
         end else begin
            // mode 0 marks the drop with one empty closing beat.
            flt_tkeep = '0;
            flt_tlast = 1'b1;
         end
      end
   end

   // ========================================
   // packet tracking
   // ========================================
   always_comb begin
      state_nxt = state;
      if (in_xfer) begin
         if (in_tlast) begin
            state_nxt = idle_sop;
         end else if (match) begin
            state_nxt = discard;
         end else if (state == idle_sop) begin
            state_nxt = pass;
         end
      end
   end

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         state <= idle_sop;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

// File: src/hdr_prefix_insert.sv
module hdr_prefix_insert
   import hdr_proc_pkg::*;
#(
   parameter int BIGENDIAN        = 0,
   parameter int MAX_PREFIX_WORDS = 4
) (
   input  logic                         axi4s_in,
   input  logic                         arst_n,
   // filtered stream in.
   input  logic                         flt_tvalid,
   input  data_t                        flt_tdata,
   input  keep_t                        flt_tkeep,
   input  logic                         flt_tlast,
   output logic                         flt_tready,
   // prefix configuration.
   // byte k of word w sits at prefix_data[w][8*k +: 8].
   input  pfx_cnt_t                     prefix_words,
   input  data_t [MAX_PREFIX_WORDS-1:0] prefix_data,
   // prefixed stream out.
   output logic                         pfx_tvalid,
   output data_t                        pfx_tdata,
   output keep_t                        pfx_tkeep,
   output logic                         pfx_tlast,
   input  logic                         pfx_tready
);

   logic     pipe_valid;
   data_t    pipe_tdata;
   keep_t    pipe_tkeep;
   logic     pipe_tlast;
   logic     pipe_pop;
   logic     add_prefix;
   pfx_cnt_t pfx_idx;
   pfx_cnt_t pfx_count;
   data_t    pfx_word;
   data_t    pfx_lanes;

   // ========================================
   // register stage
   // ========================================

   // the held word leaves only once all prefix beats are out.
   assign pipe_pop   = pipe_valid && pfx_tready && !add_prefix;
   assign flt_tready = !pipe_valid || pipe_pop;

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         pipe_valid <= 1'b0;
      end else if (flt_tready) begin
         pipe_valid <= flt_tvalid;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (flt_tvalid && flt_tready) begin
         pipe_tdata <= flt_tdata;
         pipe_tkeep <= flt_tkeep;
         pipe_tlast <= flt_tlast;
      end
   end

   // ========================================
   // prefix sequencing
   // ========================================

   // count is clipped to the words the port can hold.
   assign pfx_count  = (prefix_words > pfx_cnt_t'(MAX_PREFIX_WORDS)) ?
                       pfx_cnt_t'(MAX_PREFIX_WORDS) : prefix_words;
   assign add_prefix = pipe_valid && (pfx_idx < pfx_count);

   // index parks at the count for the body and clears on last.
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         pfx_idx <= '0;
      end else if (pfx_tvalid && pfx_tready) begin
         if (add_prefix) begin
            pfx_idx <= pfx_idx + 1'b1;
         end else if (pipe_tlast) begin
            pfx_idx <= '0;
         end
      end
   end

   // select the word and order its bytes into lanes.
   always_comb begin
      pfx_word = '0;
      for (int w = 0; w < MAX_PREFIX_WORDS; w++) begin
         if (pfx_idx == pfx_cnt_t'(w)) begin
            pfx_word = prefix_data[w];
         end
      end
      for (int k = 0; k < DATA_BYTES; k++) begin
         if (BIGENDIAN != 0) begin
            pfx_lanes[8*(DATA_BYTES-1-k) +: 8] = pfx_word[8*k +: 8];
         end else begin
            pfx_lanes[8*k +: 8] = pfx_word[8*k +: 8];
         end
      end
   end

   // prefix beats are full words and never close the packet.
   assign pfx_tvalid = pipe_valid;
   assign pfx_tdata  = add_prefix ? pfx_lanes : pipe_tdata;
   assign pfx_tkeep  = add_prefix ? '1        : pipe_tkeep;
   assign pfx_tlast  = add_prefix ? 1'b0      : pipe_tlast;

endmodule

// File: src/hdr_truncate.sv
module hdr_truncate
   import hdr_proc_pkg::*;
#(
   parameter int BIGENDIAN = 0
) (
   input  logic      axi4s_in,
   input  logic      arst_n,
   // prefixed stream in.
   input  logic      pfx_tvalid,
   input  data_t     pfx_tdata,
   input  keep_t     pfx_tkeep,
   input  logic      pfx_tlast,
   output logic      pfx_tready,
   // length limit where zero disables the cut.
   input  byte_len_t trunc_length,
   // truncated stream out.
   output logic      out_tvalid,
   output data_t     out_tdata,
   output keep_t     out_tkeep,
   output logic      out_tlast,
   input  logic      out_tready
);

   trunc_state_t state;
   byte_len_t    byte_cnt;
   byte_len_t    beat_bytes;
   byte_len_t    remaining;
   keep_t        trim_mask;
   logic         reach;

   // ========================================
   // length arithmetic
   // ========================================
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         beat_bytes = beat_bytes + byte_len_t'(pfx_tkeep[i]);
      end
   end

   // byte_cnt stays below trunc_length while in keep.
   assign remaining = trunc_length - byte_cnt;
   assign reach     = (trunc_length != '0) && (beat_bytes >= remaining);

   // keep bytes 0 to remaining-1 in stream order.
   always_comb begin
      for (int k = 0; k < DATA_BYTES; k++) begin
         if (BIGENDIAN != 0) begin
            trim_mask[DATA_BYTES-1-k] = (byte_len_t'(k) < remaining);
         end else begin
            trim_mask[k] = (byte_len_t'(k) < remaining);
         end
      end
   end

   // ========================================
   // output path
   // ========================================

   // flush drains the tail with ready high and valid low.
   assign out_tvalid = (state == keep) && pfx_tvalid;
   assign pfx_tready = (state == flush) || out_tready;
   assign out_tdata  = pfx_tdata;
   assign out_tkeep  = reach ? (pfx_tkeep & trim_mask) : pfx_tkeep;
   assign out_tlast  = pfx_tlast || reach;

   // ========================================
   // byte counter and state
   // ========================================
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         state    <= keep;
         byte_cnt <= '0;
      end else if (state == flush) begin
         if (pfx_tvalid && pfx_tlast) begin
            state <= keep;
         end
      end else if (out_tvalid && out_tready) begin
         if (out_tlast) begin
            byte_cnt <= '0;
            // cut short, so the input tail still has to go.
            if (!pfx_tlast) begin
               state <= flush;
            end
         end else begin
            byte_cnt <= byte_cnt + beat_bytes;
         end
      end
   end

endmodule

// File: src/hdr_proc.sv
module hdr_proc
   import hdr_proc_pkg::*;
#(
   parameter int BIGENDIAN        = 0,
   parameter int MAX_PREFIX_WORDS = 4
) (
   input  logic                         axi4s_in,
   input  logic                         arst_n,
   // input stream.
   input  logic                         in_tvalid,
   input  data_t                        in_tdata,
   input  keep_t                        in_tkeep,
   input  logic                         in_tlast,
   output logic                         in_tready,
   // output stream.
   output logic                         out_tvalid,
   output data_t                        out_tdata,
   output keep_t                        out_tkeep,
   output logic                         out_tlast,
   input  logic                         out_tready,
   // configuration held stable between packets.
   input  logic                         drop_enable,
   input  logic                         drop_mode,
   input  data_t                        drop_pattern,
   input  pfx_cnt_t                     prefix_words,
   input  data_t [MAX_PREFIX_WORDS-1:0] prefix_data,
   input  byte_len_t                    trunc_length
);

   // ========================================
   // stage links
   // ========================================

   // drop filter to prefix inserter.
   logic  flt_tvalid;
   data_t flt_tdata;
   keep_t flt_tkeep;
   logic  flt_tlast;
   logic  flt_tready;

   // prefix inserter to truncator.
   logic  pfx_tvalid;
   data_t pfx_tdata;
   keep_t pfx_tkeep;
   logic  pfx_tlast;
   logic  pfx_tready;

   // ========================================
   // stages
   // ========================================

   // combinational first word compare.
   hdr_drop_filter u_drop_filter (
      .axi4s_in     (axi4s_in),
      .arst_n       (arst_n),
      .in_tvalid    (in_tvalid),
      .in_tdata     (in_tdata),
      .in_tkeep     (in_tkeep),
      .in_tlast     (in_tlast),
      .in_tready    (in_tready),
      .drop_enable  (drop_enable),
      .drop_mode    (drop_mode),
      .drop_pattern (drop_pattern),
      .flt_tvalid   (flt_tvalid),
      .flt_tdata    (flt_tdata),
      .flt_tkeep    (flt_tkeep),
      .flt_tlast    (flt_tlast),
      .flt_tready   (flt_tready)
   );

   // the only register stage in the chain.
   hdr_prefix_insert #(
      .BIGENDIAN        (BIGENDIAN),
      .MAX_PREFIX_WORDS (MAX_PREFIX_WORDS)
   ) u_prefix_insert (
      .axi4s_in     (axi4s_in),
      .arst_n       (arst_n),
      .flt_tvalid   (flt_tvalid),
      .flt_tdata    (flt_tdata),
      .flt_tkeep    (flt_tkeep),
      .flt_tlast    (flt_tlast),
      .flt_tready   (flt_tready),
      .prefix_words (prefix_words),
      .prefix_data  (prefix_data),
      .pfx_tvalid   (pfx_tvalid),
      .pfx_tdata    (pfx_tdata),
      .pfx_tkeep    (pfx_tkeep),
      .pfx_tlast    (pfx_tlast),
      .pfx_tready   (pfx_tready)
   );

   // combinational length cut.
   hdr_truncate #(
      .BIGENDIAN (BIGENDIAN)
   ) u_truncate (
      .axi4s_in     (axi4s_in),
      .arst_n       (arst_n),
      .pfx_tvalid   (pfx_tvalid),
      .pfx_tdata    (pfx_tdata),
      .pfx_tkeep    (pfx_tkeep),
      .pfx_tlast    (pfx_tlast),
      .pfx_tready   (pfx_tready),
      .trunc_length (trunc_length),
      .out_tvalid   (out_tvalid),
      .out_tdata    (out_tdata),
      .out_tkeep    (out_tkeep),
      .out_tlast    (out_tlast),
      .out_tready   (out_tready)
   );

endmodule

// File: dv/hdr_proc_properties.sv
module hdr_proc_properties
   import hdr_proc_pkg::*;
(
   input logic  axi4s_in,
   input logic  arst_n,
   input logic  out_tvalid,
   input data_t out_tdata,
   input keep_t out_tkeep,
   input logic  out_tlast,
   input logic  out_tready
);

   // failure tallies, one per assertion.
   int valid_fails   = 0;
   int payload_fails = 0;
   int reset_fails   = 0;
   int fail_count;

   assign fail_count = valid_fails + payload_fails + reset_fails;

   // ========================================
   // output back-pressure
   // ========================================

   // a stalled beat keeps valid up.
   a_valid_held: assert property (
      @(posedge axi4s_in) disable iff (!arst_n)
      (out_tvalid && !out_tready) |=> out_tvalid
   ) else begin
      valid_fails++;
      $error("out_tvalid dropped while the output beat was stalled");
   end

   // and its payload does not move.
   a_payload_held: assert property (
      @(posedge axi4s_in) disable iff (!arst_n)
      (out_tvalid && !out_tready) |=>
         ($stable(out_tdata) && $stable(out_tkeep) && $stable(out_tlast))
   ) else begin
      payload_fails++;
      $error("output data, keep or last changed while the beat was stalled");
   end

   // ========================================
   // reset
   // ========================================

   // quiet in reset and in the first cycle out of it.
   a_reset_quiet: assert property (
      @(posedge axi4s_in) (!arst_n || $rose(arst_n)) |-> !out_tvalid
   ) else begin
      reset_fails++;
      $error("out_tvalid high during reset or right after its release");
   end

endmodule

// File: dv/hdr_proc_tb.sv
module hdr_proc_tb
   import hdr_proc_pkg::*;
();

   localparam int MAX_PFX = 4;
   // cycles any single wait may take.
   localparam int LIMIT   = 2000;

   logic                axi4s_in;
   logic                arst_n;
   logic                in_tvalid;
   data_t               in_tdata;
   keep_t               in_tkeep;
   logic                in_tlast;
   logic                in_tready;
   logic                out_tvalid;
   data_t               out_tdata;
   keep_t               out_tkeep;
   logic                out_tlast;
   logic                out_tready;
   logic                drop_enable;
   logic                drop_mode;
   data_t               drop_pattern;
   pfx_cnt_t            prefix_words;
   data_t [MAX_PFX-1:0] prefix_data;
   byte_len_t           trunc_length;

   // bytes of the packet being sent in stream order.
   logic [7:0] pkt_q [$];
   // expected output items as {empty beat, last, byte}.
   logic [9:0] exp_q [$];
   int         exp_pkts;
   int         out_pkts;
   int         errors;
   int         timeouts;
   logic       bp_on;

   hdr_proc #(
      .BIGENDIAN        (1),
      .MAX_PREFIX_WORDS (MAX_PFX)
   ) DUT (.*);

   bind hdr_proc hdr_proc_properties u_props (
      .axi4s_in   (axi4s_in),
      .arst_n     (arst_n),
      .out_tvalid (out_tvalid),
      .out_tdata  (out_tdata),
      .out_tkeep  (out_tkeep),
      .out_tlast  (out_tlast),
      .out_tready (out_tready)
   );

   // ========================================
   // clock and sink
   // ========================================
   initial begin
      axi4s_in = 1'b0;
      forever #5 axi4s_in = ~axi4s_in;
   end

   // sink stalls about one cycle in four when enabled.
   initial begin
      out_tready = 1'b1;
      forever begin
         @(posedge axi4s_in);
         #1;
         out_tready = !bp_on || ($urandom_range(3, 0) != 0);
      end
   end

   // ========================================
   // output checking
   // ========================================
   task automatic check_item(input logic empty, input logic last, input logic [7:0] data);
      logic [9:0] item;
      if (exp_q.size() == 0) begin
         errors++;
         $display("[ERROR] %0t: output byte arrived with nothing left expected", $time);
         return;
      end
      item = exp_q.pop_front();
      assert (item == {empty, last, data}) else begin
         errors++;
         $display("[ERROR] %0t: got empty %0b last %0b byte %02h, expected %0b %0b %02h",
                  $time, empty, last, data, item[9], item[8], item[7:0]);
      end
   endtask

   // walk the lanes in byte order starting at lane 7.
   task automatic check_beat();
      int nkeep;
      int seen;
      int lane;
      nkeep = $countones(out_tkeep);
      seen  = 0;
      if (nkeep == 0) begin
         check_item(1'b1, out_tlast, 8'h00);
      end
      for (int k = 0; k < DATA_BYTES; k++) begin
         lane = DATA_BYTES - 1 - k;
         if (out_tkeep[lane]) begin
            seen++;
            check_item(1'b0, out_tlast && (seen == nkeep), out_tdata[8*lane +: 8]);
         end
      end
      if (out_tlast) begin
         out_pkts++;
      end
   endtask

   // a beat seen here mid-cycle transfers at the next rising edge.
   always @(negedge axi4s_in) begin
      if (arst_n && out_tvalid && out_tready) begin
         check_beat();
      end
   end

   // ========================================
   // reference model
   // ========================================
   task automatic expect_packet();
      int         pfx_bytes;
      int         total;
      logic       hit;
      logic [7:0] b;
      hit = drop_enable && (pkt_q.size() >= DATA_BYTES);
      for (int j = 0; j < DATA_BYTES; j++) begin
         if (hit && (pkt_q[j] != drop_pattern[8*(DATA_BYTES-1-j) +: 8])) begin
            hit = 1'b0;
         end
      end
      // a dropped packet leaves one empty beat in mode 0 and none in mode 1.
      if (hit) begin
         if (!drop_mode) begin
            exp_q.push_back(10'h300);
            exp_pkts++;
         end
         return;
      end
      pfx_bytes = int'(prefix_words) * DATA_BYTES;
      total     = pfx_bytes + pkt_q.size();
      if ((trunc_length != '0) && (int'(trunc_length) < total)) begin
         total = int'(trunc_length);
      end
      for (int i = 0; i < total; i++) begin
         if (i < pfx_bytes) begin
            b = prefix_data[i / DATA_BYTES][8*(i % DATA_BYTES) +: 8];
         end else begin
            b = pkt_q[i - pfx_bytes];
         end
         exp_q.push_back({1'b0, (i == total - 1), b});
      end
      exp_pkts++;
   endtask

   // ========================================
   // stimulus
   // ========================================
   task automatic wait_in_ready();
      int waited;
      waited = 0;
      @(negedge axi4s_in);
      while (!in_tready && (waited < LIMIT)) begin
         @(negedge axi4s_in);
         waited++;
      end
      if (!in_tready) begin
         timeouts++;
         $display("timeout: the DUT did not accept an input beat within %0d cycles", LIMIT);
      end
      @(posedge axi4s_in);
      #1;
   endtask

   // hit forces the first word onto the drop pattern.
   task automatic send_packet(input int len, input logic hit);
      int    nwords;
      int    idx;
      data_t word;
      keep_t keep;
      pkt_q.delete();
      for (int i = 0; i < len; i++) begin
         if (hit && (i < DATA_BYTES)) begin
            pkt_q.push_back(drop_pattern[8*(DATA_BYTES-1-i) +: 8]);
         end else begin
            pkt_q.push_back(8'($urandom));
         end
      end
      expect_packet();
      nwords = (len + DATA_BYTES - 1) / DATA_BYTES;
      for (int w = 0; w < nwords; w++) begin
         word = '0;
         keep = '0;
         for (int j = 0; j < DATA_BYTES; j++) begin
            idx = w * DATA_BYTES + j;
            if (idx < len) begin
               word[8*(DATA_BYTES-1-j) +: 8] = pkt_q[idx];
               keep[DATA_BYTES-1-j]          = 1'b1;
            end
         end
         in_tvalid = 1'b1;
         in_tdata  = word;
         in_tkeep  = keep;
         in_tlast  = (w == nwords - 1);
         wait_in_ready();
      end
      in_tvalid = 1'b0;
      in_tlast  = 1'b0;
   endtask

   // a few idle cycles let the truncator finish flushing a tail.
   task automatic drain();
      int waited;
      waited = 0;
      while (((out_pkts != exp_pkts) || (exp_q.size() != 0)) && (waited < LIMIT)) begin
         @(posedge axi4s_in);
         waited++;
      end
      if ((out_pkts != exp_pkts) || (exp_q.size() != 0)) begin
         timeouts++;
         $display("timeout: output stalled with %0d packets and %0d bytes still expected",
                  exp_pkts - out_pkts, exp_q.size());
      end
      repeat (3) @(posedge axi4s_in);
      #1;
   endtask

   // configuration only changes while the DUT is idle.
   task automatic run_phase(input logic en, input logic mode, input pfx_cnt_t pw,
                            input byte_len_t tl, input int npkts);
      drop_enable  = en;
      drop_mode    = mode;
      prefix_words = pw;
      trunc_length = tl;
      for (int i = 0; i < npkts; i++) begin
         if (en && (i % 2 == 0)) begin
            send_packet($urandom_range(40, 8), 1'b1);
         end else begin
            send_packet($urandom_range(40, 1), 1'b0);
         end
      end
      drain();
   endtask

   // ========================================
   // main sequence
   // ========================================
   initial begin
      void'($urandom(32'ha1c4_1a68));
      arst_n       = 1'b0;
      in_tvalid    = 1'b0;
      in_tdata     = '0;
      in_tkeep     = '0;
      in_tlast     = 1'b0;
      bp_on        = 1'b0;
      drop_enable  = 1'b0;
      drop_mode    = 1'b0;
      drop_pattern = 64'h5a3c_96e1_0f78_c2b4;
      prefix_words = '0;
      trunc_length = '0;
      for (int w = 0; w < MAX_PFX; w++) begin
         prefix_data[w] = {$urandom, $urandom};
      end
      exp_pkts = 0;
      out_pkts = 0;
      errors   = 0;
      timeouts = 0;
      repeat (8) @(posedge axi4s_in);
      #1;
      arst_n = 1'b1;
      repeat (2) @(posedge axi4s_in);
      #1;
      // plain passthrough with a free sink.
      run_phase(1'b0, 1'b0, 4'd0, 16'd0, 12);
      bp_on = 1'b1;
      for (int p = 1; p <= MAX_PFX; p++) begin
         run_phase(1'b0, 1'b0, pfx_cnt_t'(p), 16'd0, 4);
      end
      // cuts may land inside the prefix or the payload.
      for (int t = 0; t < 6; t++) begin
         run_phase(1'b0, 1'b0, pfx_cnt_t'(t % 3), byte_len_t'($urandom_range(48, 1)), 5);
      end
      run_phase(1'b1, 1'b0, 4'd0, 16'd0, 6);
      run_phase(1'b1, 1'b1, 4'd0, 16'd0, 6);
      run_phase(1'b0, 1'b0, 4'd3, 16'd30, 16);
      $display("errors: %0d data, %0d timeout, %0d property",
               errors, timeouts, DUT.u_props.fail_count);
      if ((errors == 0) && (timeouts == 0) && (DUT.u_props.fail_count == 0)) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: project.f
src/hdr_proc_pkg.sv
src/hdr_drop_filter.sv
src/hdr_prefix_insert.sv
src/hdr_truncate.sv
src/hdr_proc.sv
dv/hdr_proc_properties.sv
dv/hdr_proc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= hdr_proc_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

# build, run, and pass only if the pass message shows up.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
